/* xbar16x8.f */
verilog/xbar_pkg.sv
verilog/bcast_tree.sv
verilog/cmd_tree.sv
verilog/col_mux.sv
verilog/xbar_half.sv
verilog/half_merge.sv
verilog/xbar16x8.sv
test/xbar16x8_props.sv
test/tb_xbar16x8.sv

/* test/tb_xbar16x8.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_xbar16x8;
	import xbar_pkg::*;

	localparam int RST_CYC    = 8;
	localparam int LEN_RESET  = 2 * XBAR_LAT;
	localparam int LEN_SINGLE = N_IN * N_OUT * (XBAR_LAT + 1);
	localparam int LEN_PERM   = 200 + XBAR_LAT;
	localparam int LEN_CONF   = 3 * N_OUT + XBAR_LAT;
	localparam int LEN_EMPTY  = 2 * N_OUT + XBAR_LAT;
	localparam int LEN_STALL  = 300 + XBAR_LAT;
	localparam int CYC_LIMIT  = RST_CYC + LEN_RESET + LEN_SINGLE + LEN_PERM + LEN_CONF
		+ LEN_EMPTY + LEN_STALL + 50;

	logic         clk;
	logic         i_arst_n;
	logic         i_en;
	vld_in_t      i_valid;
	lanes_in_t    i_data;
	cmd_t         i_cmd;
	vld8_t        o_valid;
	lanes_half_t  o_data;

	vld8_t        exp_vld_q [$];    // model results still in flight
	lanes_half_t  exp_dat_q [$];
	vld8_t        last_vld;         // model result now due on the outputs
	lanes_half_t  last_dat;
	int           cycles;
	int           n_checks;
	int           n_errors;
	int           n_tests;
	int           err_at_start;

	xbar16x8 dut0 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_en     (i_en),
		.i_valid  (i_valid),
		.i_data   (i_data),
		.i_cmd    (i_cmd),
		.o_valid  (o_valid),
		.o_data   (o_data)
	);

	bind xbar16x8 xbar16x8_props u_props (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_en     (i_en),
		.o_valid  (o_valid),
		.o_data   (o_data)
	);

	initial
		clk = 1'b0;
	always #10 clk = ~clk;

	// expected outputs for one set of inputs
	task automatic route_model(input vld_in_t v, input lanes_in_t d, input cmd_t c,
		output vld8_t ov, output lanes_half_t od);
		int     hits;
		int     src;
		int     offers;
		data_t  lane;
		ov = '0;
		od = '0;
		for (int o = 0; o < N_OUT; o++)
		begin
			offers = 0;
			lane   = '0;
			for (int h = 0; h < N_HALF; h++)
			begin
				hits = 0;
				src  = 0;
				for (int i = h * HALF_IN; i < (h + 1) * HALF_IN; i++)
				begin
					if (c[i*N_OUT + o])
					begin
						hits++;
						src = i;
					end
				end
				if (hits == 1 && v[src])    // this half offers a lane
				begin
					offers++;
					lane = d[src*DATA_W +: DATA_W];
				end
			end
			if (offers == 1)
			begin
				ov[o]                      = 1'b1;
				od[o*DATA_W +: DATA_W]     = lane;
			end
		end
	endtask

	task automatic check_vld(string sig, vld8_t exp, vld8_t act);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, sig, exp, act);
		end
	endtask

	task automatic check_dat(string sig, lanes_half_t exp, lanes_half_t act);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, sig, exp, act);
		end
	endtask

	// one clock edge then a compare of the settled outputs
	task automatic tick();
		vld8_t        m_vld;
		lanes_half_t  m_dat;
		logic         en;
		route_model(i_valid, i_data, i_cmd, m_vld, m_dat);
		en = i_en;
		@(posedge clk);
		#2;
		if (en)
		begin
			exp_vld_q.push_back(m_vld);
			exp_dat_q.push_back(m_dat);
			last_vld = exp_vld_q.pop_front();
			last_dat = exp_dat_q.pop_front();
			check_vld("o_valid", last_vld, o_valid);
			check_dat("o_data", last_dat, o_data);
		end
		else
		begin
			check_vld("o_valid (stall hold)", last_vld, o_valid);
			check_dat("o_data (stall hold)", last_dat, o_data);
		end
	endtask

	function automatic lanes_in_t rand_lanes();
		lanes_in_t d;
		for (int i = 0; i < N_IN; i++)
			d[i*DATA_W +: DATA_W] = $urandom;
		return d;
	endfunction

	// each output gets its own distinct source
	function automatic cmd_t rand_perm();
		int    pool [N_IN];
		int    j;
		int    tmp;
		cmd_t  c;
		for (int k = 0; k < N_IN; k++)
			pool[k] = k;
		for (int k = N_IN - 1; k > 0; k--)
		begin
			j       = $urandom_range(k, 0);
			tmp     = pool[k];
			pool[k] = pool[j];
			pool[j] = tmp;
		end
		c = '0;
		for (int o = 0; o < N_OUT; o++)
			c[pool[o]*N_OUT + o] = 1'b1;
		return c;
	endfunction

	task automatic drive(logic en, vld_in_t v, lanes_in_t d, cmd_t c);
		i_en    = en;
		i_valid = v;
		i_data  = d;
		i_cmd   = c;
	endtask

	task automatic drain();
		for (int k = 0; k < XBAR_LAT; k++)
		begin
			drive(1'b1, vld_in_t'($urandom), rand_lanes(), '0);
			tick();
		end
	endtask

	task automatic end_test(string name);
		n_tests++;
		$display("test %-8s done, %0d errors", name, n_errors - err_at_start);
		err_at_start = n_errors;
	endtask

	initial
	begin
		cycles = 0;
		while (cycles < CYC_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run passed %0d cycles without finishing", CYC_LIMIT);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		int    first;
		int    src;
		int    a;
		int    b;
		int    run;
		logic  en;
		cmd_t  c;
		vld_in_t v;
		void'($urandom(32'h62f7a19b));
		n_checks     = 0;
		n_errors     = 0;
		n_tests      = 0;
		err_at_start = 0;
		last_vld     = '0;
		last_dat     = '0;
		i_arst_n     = 1'b1;
		drive(1'b1, '0, '0, '0);
		#1 i_arst_n  = 1'b0;
		repeat (RST_CYC)
		begin
			@(posedge clk);
			#2;
			check_vld("o_valid", '0, o_valid);
			check_dat("o_data", '0, o_data);
		end
		i_arst_n = 1'b1;
		for (int k = 0; k < XBAR_LAT - 1; k++)    // pipeline holds reset zeros
		begin
			exp_vld_q.push_back('0);
			exp_dat_q.push_back('0);
		end

		// nothing valid until the first lane has gone through
		first = 0;
		for (int k = 0; k < LEN_RESET; k++)
		begin
			drive(1'b1, '1, rand_lanes(), rand_perm());
			tick();
			if (first == 0 && o_valid != '0)
				first = k + 1;
		end
		n_checks++;
		if (first != XBAR_LAT)
		begin
			n_errors++;
			$display("first valid output came after %0d cycles, expected %0d", first, XBAR_LAT);
		end
		end_test("reset");

		for (int i = 0; i < N_IN; i++)
		begin
			for (int o = 0; o < N_OUT; o++)
			begin
				c = '0;
				c[i*N_OUT + o] = 1'b1;
				drive(1'b1, '1, rand_lanes(), c);
				tick();
				drain();
			end
		end
		end_test("single");

		for (int k = 0; k < 200; k++)
		begin
			drive(1'b1, vld_in_t'($urandom), rand_lanes(), rand_perm());
			tick();
		end
		drain();
		end_test("perm");

		for (int o = 0; o < N_OUT; o++)
		begin
			// two sources in one half
			c   = '0;
			src = $urandom_range(N_HALF - 1, 0) * HALF_IN;
			a   = $urandom_range(HALF_IN - 1, 0);
			b   = (a + $urandom_range(HALF_IN - 1, 1)) % HALF_IN;
			c[(src + a)*N_OUT + o] = 1'b1;
			c[(src + b)*N_OUT + o] = 1'b1;
			drive(1'b1, '1, rand_lanes(), c);
			tick();
			// one valid source in each half
			a = $urandom_range(HALF_IN - 1, 0);
			b = HALF_IN + $urandom_range(HALF_IN - 1, 0);
			c = '0;
			c[a*N_OUT + o] = 1'b1;
			c[b*N_OUT + o] = 1'b1;
			drive(1'b1, '1, rand_lanes(), c);
			tick();
			// same pair with only one of them valid
			v = '1;
			if ($urandom_range(1, 0))
				v[a] = 1'b0;
			else
				v[b] = 1'b0;
			drive(1'b1, v, rand_lanes(), c);
			tick();
		end
		drain();
		end_test("conflict");

		for (int o = 0; o < N_OUT; o++)
		begin
			src = $urandom_range(N_IN - 1, 0);
			c   = '0;
			c[src*N_OUT + o] = 1'b1;
			v = vld_in_t'($urandom);
			v[src] = 1'b0;    // routed source is invalid
			drive(1'b1, v, rand_lanes(), c);
			tick();
			drive(1'b1, '1, rand_lanes(), '0);
			tick();
		end
		drain();
		end_test("empty");

		// random runs of enabled and stalled edges
		en  = 1'b1;
		run = $urandom_range(8, 1);
		for (int k = 0; k < 300; k++)
		begin
			if (run == 0)
			begin
				en  = ~en;
				run = en ? $urandom_range(8, 1) : $urandom_range(5, 1);
			end
			run--;
			drive(en, vld_in_t'($urandom), rand_lanes(), rand_perm());
			tick();
		end
		drain();
		end_test("stall");

		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* test/xbar16x8_props.sv */
`timescale 1ns/1ns
`default_nettype none

// checks on the crossbar outputs, bound into xbar16x8
module xbar16x8_props (
	input  wire                           clk,
	input  wire                           i_arst_n,
	input  wire                           i_en,
	input  wire xbar_pkg::vld8_t          o_valid,
	input  wire xbar_pkg::lanes_half_t    o_data
);
	import xbar_pkg::*;

	// an invalid lane carries zero data
	for (genvar k = 0; k < N_OUT; k++)
	begin : g_lane
		a_idle_zero : assert property (@(posedge clk) disable iff (!i_arst_n)
			!o_valid[k] |-> o_data[k*DATA_W +: DATA_W] == '0)
			else $error("output lane %0d carries data while its valid bit is low", k);
	end

	// stalled edge leaves the outputs as they were
	a_stall_hold : assert property (@(posedge clk) disable iff (!i_arst_n)
		!i_en |=> $stable(o_valid) && $stable(o_data))
		else $error("outputs changed across an edge with i_en low");

	a_reset_clear : assert property (@(posedge clk)
		!i_arst_n |-> o_valid == '0)
		else $error("o_valid is not zero during reset");

endmodule

`default_nettype wire

/* verilog/xbar16x8.sv */
`timescale 1ns/1ns
`default_nettype none

// 16-in 8-out crossbar, two 8x8 halves then a merge
module xbar16x8 (
	input  wire                           clk,
	input  wire                           i_arst_n,
	input  wire                           i_en,
	input  wire xbar_pkg::vld_in_t        i_valid,
	input  wire xbar_pkg::lanes_in_t      i_data,
	input  wire xbar_pkg::cmd_t           i_cmd,
	output xbar_pkg::vld8_t               o_valid,
	output xbar_pkg::lanes_half_t         o_data
);
	import xbar_pkg::*;

	vld8_t        half_valid [N_HALF];
	lanes_half_t  half_data  [N_HALF];

	// half h takes inputs h*8..h*8+7 and their command rows
	for (genvar h = 0; h < N_HALF; h++)
	begin : g_half
		xbar_half u_half (
			.clk      (clk),
			.i_arst_n (i_arst_n),
			.i_en     (i_en),
			.i_valid  (i_valid[h*HALF_IN +: HALF_IN]),
			.i_data   (i_data[h*HALF_IN*DATA_W +: HALF_IN*DATA_W]),
			.i_cmd    (i_cmd[h*HALF_IN*N_OUT +: HALF_IN*N_OUT]),
			.o_valid  (half_valid[h]),
			.o_data   (half_data[h])
		);
	end

	half_merge u_merge (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_en       (i_en),
		.i_valid_lo (half_valid[0]),
		.i_data_lo  (half_data[0]),
		.i_valid_hi (half_valid[1]),
		.i_data_hi  (half_data[1]),
		.o_valid    (o_valid),
		.o_data     (o_data)
	);

endmodule

`default_nettype wire

/* verilog/half_merge.sv */
`timescale 1ns/1ns
`default_nettype none

// final stage, per output takes whichever half alone is valid
module half_merge (
	input  wire                           clk,
	input  wire                           i_arst_n,
	input  wire                           i_en,
	input  wire xbar_pkg::vld8_t          i_valid_lo,
	input  wire xbar_pkg::lanes_half_t    i_data_lo,
	input  wire xbar_pkg::vld8_t          i_valid_hi,
	input  wire xbar_pkg::lanes_half_t    i_data_hi,
	output xbar_pkg::vld8_t               o_valid,
	output xbar_pkg::lanes_half_t         o_data
);
	import xbar_pkg::*;

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_valid <= '0;
			o_data  <= '0;
		end
		else if (i_en)
		begin
			for (int k = 0; k < N_OUT; k++)
			begin
				case ({i_valid_hi[k], i_valid_lo[k]})
					2'b01:
					begin
						o_valid[k]                 <= 1'b1;
						o_data[k*DATA_W +: DATA_W] <= i_data_lo[k*DATA_W +: DATA_W];
					end
					2'b10:
					begin
						o_valid[k]                 <= 1'b1;
						o_data[k*DATA_W +: DATA_W] <= i_data_hi[k*DATA_W +: DATA_W];
					end
					default:    // both halves or neither
					begin
						o_valid[k]                 <= 1'b0;
						o_data[k*DATA_W +: DATA_W] <= '0;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/xbar_half.sv */
`timescale 1ns/1ns
`default_nettype none

// 8x8 switch: fanout trees per input, one select per output column
module xbar_half (
	input  wire                           clk,
	input  wire                           i_arst_n,
	input  wire                           i_en,
	input  wire xbar_pkg::vld8_t          i_valid,
	input  wire xbar_pkg::lanes_half_t    i_data,
	input  wire xbar_pkg::cmd_half_t      i_cmd,
	output xbar_pkg::vld8_t               o_valid,
	output xbar_pkg::lanes_half_t         o_data
);
	import xbar_pkg::*;

	// tree outputs, indexed by input then column
	vld8_t        tr_valid [HALF_IN];
	lanes_half_t  tr_data  [HALF_IN];
	vld8_t        tr_cmd   [HALF_IN];

	// regrouped per column, indexed by source input
	vld8_t        col_valid [N_OUT];
	lanes_half_t  col_data  [N_OUT];
	vld8_t        col_sel   [N_OUT];

	for (genvar i = 0; i < HALF_IN; i++)
	begin : g_in
		bcast_tree u_bcast (
			.clk      (clk),
			.i_arst_n (i_arst_n),
			.i_en     (i_en),
			.i_valid  (i_valid[i]),
			.i_data   (i_data[i*DATA_W +: DATA_W]),
			.o_valid  (tr_valid[i]),
			.o_data   (tr_data[i])
		);

		cmd_tree u_cmd (
			.clk      (clk),
			.i_arst_n (i_arst_n),
			.i_en     (i_en),
			.i_cmd    (i_cmd[i*N_OUT +: N_OUT]),    // row of input i
			.o_cmd    (tr_cmd[i])
		);
	end

	// transpose input-major to column-major
	for (genvar o = 0; o < N_OUT; o++)
	begin : g_col
		for (genvar i = 0; i < HALF_IN; i++)
		begin : g_src
			assign col_valid[o][i]                = tr_valid[i][o];
			assign col_sel[o][i]                  = tr_cmd[i][o];
			assign col_data[o][i*DATA_W +: DATA_W] = tr_data[i][o*DATA_W +: DATA_W];
		end

		col_mux u_mux (
			.clk      (clk),
			.i_arst_n (i_arst_n),
			.i_en     (i_en),
			.i_valid  (col_valid[o]),
			.i_data   (col_data[o]),
			.i_sel    (col_sel[o]),
			.o_valid  (o_valid[o]),
			.o_data   (o_data[o*DATA_W +: DATA_W])
		);
	end

endmodule

`default_nettype wire

/* verilog/col_mux.sv */
`timescale 1ns/1ns
`default_nettype none

// one output column of a half: picks the lane named by a one-hot select
module col_mux (
	input  wire                           clk,
	input  wire                           i_arst_n,
	input  wire                           i_en,
	input  wire xbar_pkg::vld8_t          i_valid,
	input  wire xbar_pkg::lanes_half_t    i_data,
	input  wire xbar_pkg::vld8_t          i_sel,
	output logic                          o_valid,
	output xbar_pkg::data_t               o_data
);
	import xbar_pkg::*;

	logic   one_hot;
	logic   hit;
	data_t  pick;

	// and-or select, only meaningful when i_sel is one-hot
	always_comb
	begin
		pick = '0;
		for (int k = 0; k < HALF_IN; k++)
		begin
			if (i_sel[k])
			begin
				pick = pick | i_data[k*DATA_W +: DATA_W];
			end
		end
	end

	assign one_hot = (i_sel != '0) && ((i_sel & (i_sel - 1'b1)) == '0);
	assign hit     = one_hot && ((i_sel & i_valid) != '0);    // chosen source is valid

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_valid <= 1'b0;
			o_data  <= '0;
		end
		else if (i_en)
		begin
			o_valid <= hit;
			o_data  <= hit ? pick : '0;    // conflicts and empty selects give zero
		end
	end

endmodule

`default_nettype wire

/* verilog/cmd_tree.sv */
`timescale 1ns/1ns
`default_nettype none

// splits one input's command row down to one bit per output column,
// same depth as bcast_tree so command lines up with the lane it steers
module cmd_tree (
	input  wire                        clk,
	input  wire                        i_arst_n,
	input  wire                        i_en,
	input  wire [xbar_pkg::N_OUT-1:0]  i_cmd,
	output xbar_pkg::vld8_t            o_cmd
);
	import xbar_pkg::*;

	// level l has 2**l branches of N_OUT>>l bits each
	for (genvar l = 0; l < TREE_LVLS; l++)
	begin : g_lvl
		logic [(1<<l)-1:0][(N_OUT>>l)-1:0] br;

		if (l == 0)
		begin : g_root
			always_ff @(posedge clk or negedge i_arst_n)
			begin
				if (!i_arst_n)
					br <= '0;
				else if (i_en)
					br[0] <= i_cmd;
			end
		end
		else
		begin : g_node
			always_ff @(posedge clk or negedge i_arst_n)
			begin
				if (!i_arst_n)
				begin
					br <= '0;
				end
				else if (i_en)
				begin
					// even child takes the low half of its parent, odd the high half
					for (int j = 0; j < (1 << l); j++)
					begin
						br[j] <= g_lvl[l-1].br[j/2][(j%2)*(N_OUT>>l) +: (N_OUT>>l)];
					end
				end
			end
		end
	end

	// leaf registers, one column bit each
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_cmd <= '0;
		end
		else if (i_en)
		begin
			for (int k = 0; k < N_OUT; k++)
			begin
				o_cmd[k] <= g_lvl[TREE_LVLS-1].br[k/2][k%2];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/bcast_tree.sv */
`timescale 1ns/1ns
`default_nettype none

// copies one lane and its valid bit out to every output column
module bcast_tree (
	input  wire                    clk,
	input  wire                    i_arst_n,
	input  wire                    i_en,
	input  wire                    i_valid,
	input  wire xbar_pkg::data_t   i_data,
	output xbar_pkg::vld8_t        o_valid,
	output xbar_pkg::lanes_half_t  o_data
);
	import xbar_pkg::*;

	// level l holds 2**l copies
	for (genvar l = 0; l < TREE_LVLS; l++)
	begin : g_lvl
		logic [(1<<l)-1:0]   vld;
		data_t [(1<<l)-1:0]  dat;

		if (l == 0)
		begin : g_root
			always_ff @(posedge clk or negedge i_arst_n)
			begin
				if (!i_arst_n)
				begin
					vld <= '0;
					dat <= '0;
				end
				else if (i_en)
				begin
					vld[0] <= i_valid;
					dat[0] <= i_data;
				end
			end
		end
		else
		begin : g_node
			always_ff @(posedge clk or negedge i_arst_n)
			begin
				if (!i_arst_n)
				begin
					vld <= '0;
					dat <= '0;
				end
				else if (i_en)
				begin
					for (int j = 0; j < (1 << l); j++)
					begin
						vld[j] <= g_lvl[l-1].vld[j/2];    // both children from one parent
						dat[j] <= g_lvl[l-1].dat[j/2];
					end
				end
			end
		end
	end

	// final doubling into the output register
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_valid <= '0;
			o_data  <= '0;
		end
		else if (i_en)
		begin
			for (int k = 0; k < N_OUT; k++)
			begin
				o_valid[k]                 <= g_lvl[TREE_LVLS-1].vld[k/2];
				o_data[k*DATA_W +: DATA_W] <= g_lvl[TREE_LVLS-1].dat[k/2];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

	// crossbar sizes
	localparam int DATA_W    = 32;
	localparam int N_IN      = 16;
	localparam int N_OUT     = 8;
	localparam int N_HALF    = 2;
	localparam int HALF_IN   = N_IN / N_HALF;

	// pipeline depth
	localparam int TREE_LVLS = 3;                 // log2 of N_OUT
	localparam int HALF_LAT  = TREE_LVLS + 2;     // tree levels, tree out reg, select
	localparam int XBAR_LAT  = HALF_LAT + 1;      // plus merge

	typedef logic [DATA_W-1:0]          data_t;
	typedef logic [N_IN*DATA_W-1:0]     lanes_in_t;
	typedef logic [HALF_IN*DATA_W-1:0]  lanes_half_t;    // also the 8 output lanes
	typedef logic [N_IN-1:0]            vld_in_t;
	typedef logic [N_OUT-1:0]           vld8_t;

	// bit i*N_OUT+o routes input i to output o
	typedef logic [N_IN*N_OUT-1:0]      cmd_t;
	typedef logic [HALF_IN*N_OUT-1:0]   cmd_half_t;

endpackage

`default_nettype wire
